// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_STR  ?= TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_STR)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/alu.sv
`timescale 1ns/1ps

module alu import isa_pkg::*; (
    input  alu_op_e i_op,
    input  word_t   i_data_a,
    input  word_t   i_data_b,
    input  shamt_t  i_shamt,
    output word_t   o_result
);

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_data_a + i_data_b;
            ALU_SUB: o_result = i_data_a - i_data_b;
            ALU_AND: o_result = i_data_a & i_data_b;
            ALU_OR:  o_result = i_data_a | i_data_b;
            ALU_XOR: o_result = i_data_a ^ i_data_b;
            ALU_NOR: o_result = ~(i_data_a | i_data_b);
            // signed compare, result is 0 or 1
            ALU_SLT: begin
                if ($signed(i_data_a) < $signed(i_data_b)) begin
                    o_result = 32'd1;
                end else begin
                    o_result = 32'd0;
                end
            end
            // shifts act on b, as in the ISA
            ALU_SLL: o_result = i_data_b << i_shamt;
            ALU_SRL: o_result = i_data_b >> i_shamt;
            ALU_SRA: o_result = word_t'($signed(i_data_b) >>> i_shamt);
            ALU_LUI: o_result = {i_data_b[15:0], 16'h0000};
            default: o_result = '0;
        endcase
    end

endmodule

// File: design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_halt,
    input  id_ex_t   i_id_ex,
    input  fwd_sel_e i_fw_a,
    input  fwd_sel_e i_fw_b,
    input  word_t    i_mem_wb_data,
    output ex_mem_t  o_ex_mem
);

    word_t   op_a;
    word_t   op_b_fwd;
    word_t   op_b;
    word_t   alu_result;
    ex_mem_t ex_mem_d;

    function automatic word_t fwd_mux(
        input fwd_sel_e sel,
        input word_t    reg_val,
        input word_t    ex_mem_val,
        input word_t    mem_wb_val
    );
        word_t val;
        case (sel)
            FWD_EX_MEM: val = ex_mem_val;
            FWD_MEM_WB: val = mem_wb_val;
            default:    val = reg_val;
        endcase
        return val;
    endfunction

    // EX/MEM result comes back from our own output register
    assign op_a     = fwd_mux(i_fw_a, i_id_ex.reg_a, o_ex_mem.result, i_mem_wb_data);
    assign op_b_fwd = fwd_mux(i_fw_b, i_id_ex.reg_b, o_ex_mem.result, i_mem_wb_data);

    // immediate replaces b only after the store data is taken
    assign op_b = i_id_ex.ctrl.imm_sel ? i_id_ex.imm : op_b_fwd;

    alu alu_i (
        .i_op     (i_id_ex.ctrl.alu_op),
        .i_data_a (op_a),
        .i_data_b (op_b),
        .i_shamt  (i_id_ex.shamt),
        .o_result (alu_result)
    );

    always_comb begin
        ex_mem_d            = '0;
        ex_mem_d.valid      = i_id_ex.valid;
        ex_mem_d.reg_write  = i_id_ex.ctrl.reg_write;
        ex_mem_d.mem_read   = i_id_ex.ctrl.mem_read;
        ex_mem_d.mem_write  = i_id_ex.ctrl.mem_write;
        ex_mem_d.dest       = i_id_ex.dest;
        ex_mem_d.result     = alu_result;
        ex_mem_d.store_data = op_b_fwd;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ex_mem <= '0;
        end else if (!i_halt) begin
            o_ex_mem <= ex_mem_d;
        end
    end

endmodule

// File: design/exec_core_top.sv
`timescale 1ns/1ps

module exec_core_top import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_halt,
    input  logic     i_instr_valid,
    input  word_t    i_instr,
    output logic     o_wb_valid,
    output reg_idx_t o_wb_reg,
    output word_t    o_wb_data
);

    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    word_t    rdata_a;
    word_t    rdata_b;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    fwd_sel_e fw_a;
    fwd_sel_e fw_b;
    logic     wb_we;

    // writeback is frozen along with the stage registers
    assign wb_we = mem_wb.valid & ~i_halt;

    assign o_wb_valid = mem_wb.valid;
    assign o_wb_reg   = mem_wb.dest;
    assign o_wb_data  = mem_wb.data;

    id_stage id_stage_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_halt        (i_halt),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_rdata_a     (rdata_a),
        .i_rdata_b     (rdata_b),
        .o_raddr_a     (raddr_a),
        .o_raddr_b     (raddr_b),
        .o_id_ex       (id_ex)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_we      (wb_we),
        .i_waddr   (mem_wb.dest),
        .i_wdata   (mem_wb.data),
        .i_raddr_a (raddr_a),
        .i_raddr_b (raddr_b),
        .o_rdata_a (rdata_a),
        .o_rdata_b (rdata_b)
    );

    fwd_unit fwd_unit_i (
        .i_id_ex  (id_ex),
        .i_ex_mem (ex_mem),
        .i_mem_wb (mem_wb),
        .o_fw_a   (fw_a),
        .o_fw_b   (fw_b)
    );

    ex_stage ex_stage_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_halt        (i_halt),
        .i_id_ex       (id_ex),
        .i_fw_a        (fw_a),
        .i_fw_b        (fw_b),
        .i_mem_wb_data (mem_wb.data),
        .o_ex_mem      (ex_mem)
    );

    mem_stage mem_stage_i (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_halt   (i_halt),
        .i_ex_mem (ex_mem),
        .o_mem_wb (mem_wb)
    );

endmodule

// File: design/fwd_unit.sv
`timescale 1ns/1ps

module fwd_unit import isa_pkg::*, pipe_pkg::*; (
    input  id_ex_t   i_id_ex,
    input  ex_mem_t  i_ex_mem,
    input  mem_wb_t  i_mem_wb,
    output fwd_sel_e o_fw_a,
    output fwd_sel_e o_fw_b
);

    // nearest writer wins, EX/MEM before MEM/WB
    function automatic fwd_sel_e fwd_select(
        input reg_idx_t src,
        input ex_mem_t  ex_mem,
        input mem_wb_t  mem_wb
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if (ex_mem.valid && ex_mem.reg_write && (ex_mem.dest == src)) begin
            sel = FWD_EX_MEM;
        end else if (mem_wb.valid && (mem_wb.dest == src)) begin
            sel = FWD_MEM_WB;
        end
        return sel;
    endfunction

    assign o_fw_a = fwd_select(i_id_ex.rs, i_ex_mem, i_mem_wb);
    assign o_fw_b = fwd_select(i_id_ex.rt, i_ex_mem, i_mem_wb);

endmodule

// File: design/id_stage.sv
`timescale 1ns/1ps

module id_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_halt,
    input  logic     i_instr_valid,
    input  word_t    i_instr,
    input  word_t    i_rdata_a,
    input  word_t    i_rdata_b,
    output reg_idx_t o_raddr_a,
    output reg_idx_t o_raddr_b,
    output id_ex_t   o_id_ex
);

    opcode_t  opcode;
    func_t    func;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    shamt_t   shamt;
    imm16_t   imm16;

    ctrl_t    ctrl;
    reg_idx_t dest;
    word_t    imm_ext;
    logic     known;
    id_ex_t   id_ex_d;

    assign opcode = i_instr[31:26];
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign shamt  = i_instr[10:6];
    assign func   = i_instr[5:0];
    assign imm16  = i_instr[15:0];

    assign o_raddr_a = rs;
    assign o_raddr_b = rt;

    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = ALU_ADD;
        ctrl.reg_write = 1'b1;
        ctrl.imm_sel   = 1'b1;
        dest           = rt;
        imm_ext        = {{16{imm16[15]}}, imm16};
        known          = 1'b1;
        case (opcode)
            R_TYPE_OP: begin
                dest         = rd;
                ctrl.imm_sel = 1'b0;
                case (func)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    FN_SRL:  ctrl.alu_op = ALU_SRL;
                    FN_SRA:  ctrl.alu_op = ALU_SRA;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDI: ctrl.alu_op = ALU_ADD;
            OP_SLTI: ctrl.alu_op = ALU_SLT;
            // logic immediates are zero extended
            OP_ANDI: begin
                ctrl.alu_op = ALU_AND;
                imm_ext     = {16'h0000, imm16};
            end
            OP_ORI: begin
                ctrl.alu_op = ALU_OR;
                imm_ext     = {16'h0000, imm16};
            end
            OP_XORI: begin
                ctrl.alu_op = ALU_XOR;
                imm_ext     = {16'h0000, imm16};
            end
            OP_LUI:  ctrl.alu_op = ALU_LUI;
            OP_LW:   ctrl.mem_read = 1'b1;
            OP_SW: begin
                ctrl.reg_write = 1'b0;
                ctrl.mem_write = 1'b1;
            end
            default: known = 1'b0;
        endcase
        // writes to r0 are dropped here, once for the whole pipe
        if (dest == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    always_comb begin
        id_ex_d = '0;
        if (i_instr_valid && known) begin
            id_ex_d.valid = 1'b1;
            id_ex_d.ctrl  = ctrl;
            id_ex_d.rs    = rs;
            id_ex_d.rt    = rt;
            id_ex_d.dest  = dest;
            id_ex_d.reg_a = i_rdata_a;
            id_ex_d.reg_b = i_rdata_b;
            id_ex_d.imm   = imm_ext;
            id_ex_d.shamt = shamt;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else if (!i_halt) begin
            o_id_ex <= id_ex_d;
        end
    end

endmodule

// File: design/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [15:0] imm16_t;

    // primary opcodes
    localparam opcode_t R_TYPE_OP = 6'b000000;
    localparam opcode_t OP_ADDI   = 6'b001000;
    localparam opcode_t OP_SLTI   = 6'b001010;
    localparam opcode_t OP_ANDI   = 6'b001100;
    localparam opcode_t OP_ORI    = 6'b001101;
    localparam opcode_t OP_XORI   = 6'b001110;
    localparam opcode_t OP_LUI    = 6'b001111;
    localparam opcode_t OP_LW     = 6'b100011;
    localparam opcode_t OP_SW     = 6'b101011;

    // R-type function codes
    localparam func_t FN_SLL  = 6'b000000;
    localparam func_t FN_SRL  = 6'b000010;
    localparam func_t FN_SRA  = 6'b000011;
    localparam func_t FN_ADDU = 6'b100001;
    localparam func_t FN_SUBU = 6'b100011;
    localparam func_t FN_AND  = 6'b100100;
    localparam func_t FN_OR   = 6'b100101;
    localparam func_t FN_XOR  = 6'b100110;
    localparam func_t FN_NOR  = 6'b100111;
    localparam func_t FN_SLT  = 6'b101010;

    // data memory, word addressed through byte address bits 7:2
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

endpackage

// File: design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic    clk,
    input  logic    i_rst,
    input  logic    i_halt,
    input  ex_mem_t i_ex_mem,
    output mem_wb_t o_mem_wb
);

    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_addr;
    word_t              load_data;
    mem_wb_t            mem_wb_d;

    // word index from byte address bits 7:2
    assign word_addr = i_ex_mem.result[DMEM_AW+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (!i_halt && i_ex_mem.valid && i_ex_mem.mem_write) begin
            dmem[word_addr] <= i_ex_mem.store_data;
        end
    end

    // only writing instructions leave a valid MEM/WB entry
    always_comb begin
        mem_wb_d       = '0;
        mem_wb_d.valid = i_ex_mem.valid & i_ex_mem.reg_write;
        mem_wb_d.dest  = i_ex_mem.dest;
        if (i_ex_mem.mem_read) begin
            mem_wb_d.data = load_data;
        end else begin
            mem_wb_d.data = i_ex_mem.result;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_mem_wb <= '0;
        end else if (!i_halt) begin
            o_mem_wb <= mem_wb_d;
        end
    end

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // decoded control, carried in ID/EX
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    imm_sel;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
        word_t    reg_a;
        word_t    reg_b;
        word_t    imm;
        shamt_t   shamt;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        reg_idx_t dest;
        word_t    result;
        word_t    store_data;
    } ex_mem_t;

    // valid here means a register write is pending
    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    data;
    } mem_wb_t;

    // codes follow the EX operand mux select
    typedef enum logic [1:0] {
        FWD_REG    = 2'b00,
        FWD_MEM_WB = 2'b10,
        FWD_EX_MEM = 2'b11
    } fwd_sel_e;

endpackage

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_we,
    input  reg_idx_t i_waddr,
    input  word_t    i_wdata,
    input  reg_idx_t i_raddr_a,
    input  reg_idx_t i_raddr_b,
    output word_t    o_rdata_a,
    output word_t    o_rdata_b
);

    word_t regs [32];

    // r0 is cleared on reset and decode never enables a write to it
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // write-through so decode sees the value being written back
    always_comb begin
        if (i_we && (i_waddr == i_raddr_a)) begin
            o_rdata_a = i_wdata;
        end else begin
            o_rdata_a = regs[i_raddr_a];
        end
        if (i_we && (i_waddr == i_raddr_b)) begin
            o_rdata_b = i_wdata;
        end else begin
            o_rdata_b = regs[i_raddr_b];
        end
    end

endmodule

// File: sim.f
+incdir+tb
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_file.sv
design/id_stage.sv
design/fwd_unit.sv
design/alu.sv
design/ex_stage.sv
design/mem_stage.sv
design/exec_core_top.sv
tb/tb_exec_core.sv

// File: tb/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// architectural state, updated in program order at issue
word_t model_regs [32];
word_t model_mem  [DMEM_WORDS];

function automatic void model_reset();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    foreach (model_mem[i]) begin
        model_mem[i] = '0;
    end
endfunction

// runs one instruction, returns 1 when it writes a register
function automatic logic model_exec(input word_t instr, output reg_idx_t dest,
                                    output word_t data);
    word_t a;
    word_t b;
    word_t simm;
    word_t zimm;
    word_t addr;
    logic  writes;
    a      = model_regs[instr[25:21]];
    b      = model_regs[instr[20:16]];
    simm   = {{16{instr[15]}}, instr[15:0]};
    zimm   = {16'h0000, instr[15:0]};
    addr   = a + simm;
    dest   = instr[20:16];
    data   = '0;
    writes = 1'b1;
    case (instr[31:26])
        R_TYPE_OP: begin
            dest = instr[15:11];
            case (instr[5:0])
                FN_ADDU: data = a + b;
                FN_SUBU: data = a - b;
                FN_AND:  data = a & b;
                FN_OR:   data = a | b;
                FN_XOR:  data = a ^ b;
                FN_NOR:  data = ~(a | b);
                FN_SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLL:  data = b << instr[10:6];
                FN_SRL:  data = b >> instr[10:6];
                FN_SRA:  data = word_t'($signed(b) >>> instr[10:6]);
                default: writes = 1'b0;
            endcase
        end
        OP_ADDI: data = a + simm;
        OP_SLTI: data = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
        OP_ANDI: data = a & zimm;
        OP_ORI:  data = a | zimm;
        OP_XORI: data = a ^ zimm;
        OP_LUI:  data = {instr[15:0], 16'h0000};
        OP_LW:   data = model_mem[addr[7:2]];
        OP_SW: begin
            model_mem[addr[7:2]] = b;
            writes = 1'b0;
        end
        default: writes = 1'b0;
    endcase
    // r0 is hardwired
    if (dest == 5'd0) begin
        writes = 1'b0;
    end
    if (writes) begin
        model_regs[dest] = data;
    end
    return writes;
endfunction

`endif

// File: tb/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core import isa_pkg::*; ();

    typedef struct packed {
        logic     writes;
        reg_idx_t dest;
        word_t    data;
        word_t    instr;
    } wb_exp_t;

    // test lengths, each issue may need one load-use bubble
    localparam int RESET_IDLE_CYC = 6 + 2 * 2;
    localparam int ALU_CYC        = 150 * 2;
    localparam int DEP_CYC        = (4 + 120) * 2;
    localparam int STLD_CYC       = 40 * 5 * 2;
    localparam int MIXED_CYC      = 300 * 3;
    localparam int DRAIN_CYC      = 10;
    localparam int MAX_CYCLES     = RESET_IDLE_CYC + ALU_CYC + DEP_CYC + STLD_CYC
                                    + MIXED_CYC + DRAIN_CYC + 100;

    logic     clk = 1'b0;
    logic     i_rst;
    logic     i_halt;
    logic     i_instr_valid;
    word_t    i_instr;
    logic     o_wb_valid;
    reg_idx_t o_wb_reg;
    word_t    o_wb_data;

    wb_exp_t  exp_q [$];
    int       stamp_q [$];
    int       active_cnt = 0;
    int       cycle_cnt = 0;
    int       drive_cnt = 0;
    int       commit_cnt = 0;
    int       value_errs = 0;
    int       missing_errs = 0;
    int       extra_errs = 0;
    int       latency_errs = 0;
    reg_idx_t last_lw_dest = '0;

    `include "isa_model.svh"

    exec_core_top dut_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_halt        (i_halt),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_wb_valid    (o_wb_valid),
        .o_wb_reg      (o_wb_reg),
        .o_wb_data     (o_wb_data)
    );

    always #4 clk = ~clk;

    function automatic word_t enc_r(func_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                    shamt_t sh);
        return {R_TYPE_OP, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic reg_idx_t rand_reg(input int unsigned top);
        return reg_idx_t'($urandom_range(top, 0));
    endfunction

    // one of the 16 register-writing ALU instructions over r0..top
    function automatic word_t rand_alu(input int unsigned top);
        int unsigned pick;
        reg_idx_t    rs;
        func_t       fn;
        opcode_t     op;
        pick = $urandom_range(15, 0);
        rs   = rand_reg(top);
        fn   = FN_ADDU;
        op   = OP_ADDI;
        case (pick)
            0: fn = FN_SUBU;
            1: fn = FN_AND;
            2: fn = FN_OR;
            3: fn = FN_XOR;
            4: fn = FN_NOR;
            5: fn = FN_SLT;
            6: fn = FN_SLL;
            7: fn = FN_SRL;
            8: fn = FN_SRA;
            10: op = OP_SLTI;
            11: op = OP_ANDI;
            12: op = OP_ORI;
            13: op = OP_XORI;
            14: op = OP_LUI;
            default: ;
        endcase
        if (pick >= 6 && pick <= 8) begin
            return enc_r(fn, 5'd0, rand_reg(top), rand_reg(top), shamt_t'($urandom()));
        end else if (pick < 10) begin
            return enc_r(fn, rs, rand_reg(top), rand_reg(top), 5'd0);
        end
        if (op == OP_LUI) begin
            rs = 5'd0;
        end
        return enc_i(op, rs, rand_reg(top), imm16_t'($urandom()));
    endfunction

    function automatic word_t rand_mem();
        reg_idx_t base;
        imm16_t   off;
        base = ($urandom_range(3, 0) == 0) ? rand_reg(7) : 5'd0;
        off  = imm16_t'({$urandom_range(63, 0), 2'b00});
        if ($urandom_range(1, 0) == 1) begin
            return enc_i(OP_SW, base, rand_reg(7), off);
        end
        return enc_i(OP_LW, base, rand_reg(7), off);
    endfunction

    task automatic drive_idle();
        @(posedge clk);
        i_halt        <= 1'b0;
        i_instr_valid <= 1'b0;
        i_instr       <= $urandom();
        drive_cnt++;
        last_lw_dest = '0;
    endtask

    // a valid word offered under halt must not be taken
    task automatic drive_halt(input int unsigned n);
        repeat (n) begin
            @(posedge clk);
            i_halt        <= 1'b1;
            i_instr_valid <= 1'($urandom_range(1, 0));
            i_instr       <= $urandom();
            drive_cnt++;
        end
    endtask

    task automatic issue(input word_t instr);
        wb_exp_t  e;
        reg_idx_t dest;
        word_t    data;
        // no load-use interlock in the core, so space it with a bubble
        if (last_lw_dest != 5'd0 &&
            (instr[25:21] == last_lw_dest || instr[20:16] == last_lw_dest)) begin
            drive_idle();
        end
        @(posedge clk);
        i_halt        <= 1'b0;
        i_instr_valid <= 1'b1;
        i_instr       <= instr;
        drive_cnt++;
        e.writes = model_exec(instr, dest, data);
        e.dest   = dest;
        e.data   = data;
        e.instr  = instr;
        exp_q.push_back(e);
        last_lw_dest = (instr[31:26] == OP_LW) ? instr[20:16] : 5'd0;
    endtask

    task automatic check_commit();
        wb_exp_t e;
        int      stamp;
        commit_cnt++;
        if (o_wb_reg == 5'd0) begin
            $display("a write to r0 appeared on the writeback port");
            extra_errs++;
        end
        while (exp_q.size() > 0 && !exp_q[0].writes) begin
            e = exp_q.pop_front();
            stamp = stamp_q.pop_front();
        end
        if (exp_q.size() == 0 || stamp_q.size() == 0) begin
            $display("writeback to r%0d arrived with no write outstanding", o_wb_reg);
            extra_errs++;
        end else begin
            e = exp_q.pop_front();
            stamp = stamp_q.pop_front();
            if (o_wb_reg !== e.dest) begin
                $display("ERROR o_wb_reg: got %h expected %h (instr %h)",
                         o_wb_reg, e.dest, e.instr);
                value_errs++;
            end
            if (o_wb_data !== e.data) begin
                $display("ERROR o_wb_data: got %h expected %h (instr %h)",
                         o_wb_data, e.data, e.instr);
                value_errs++;
            end
            if (active_cnt != stamp + 3) begin
                $display("writeback of instr %h came %0d active cycles after issue, not 3",
                         e.instr, active_cnt - stamp);
                latency_errs++;
            end
        end
    endtask

    // commits count only on unhalted edges
    always @(posedge clk) begin
        if (!i_rst && !i_halt) begin
            active_cnt++;
            if (o_wb_valid) begin
                check_commit();
            end
            if (i_instr_valid) begin
                stamp_q.push_back(active_cnt);
            end
        end
    end

    function automatic int pending_writes();
        int n;
        n = 0;
        foreach (exp_q[i]) begin
            if (exp_q[i].writes) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic report_and_finish(input bit timed_out);
        int total;
        total = value_errs + missing_errs + extra_errs + latency_errs;
        $display("commits %0d, value errors %0d, missing %0d, unexpected %0d, latency %0d",
                 commit_cnt, value_errs, missing_errs, extra_errs, latency_errs);
        if (total == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (!i_rst) begin
            cycle_cnt++;
            if (cycle_cnt > MAX_CYCLES) begin
                $display("timeout after %0d cycles, %0d driven", cycle_cnt, drive_cnt);
                report_and_finish(1'b1);
            end
        end
    end

    task automatic check_reset_idle();
        repeat (6) begin
            drive_idle();
            @(negedge clk);
            if (o_wb_valid !== 1'b0) begin
                $display("ERROR o_wb_valid: got %h expected %h", o_wb_valid, 1'b0);
                value_errs++;
            end
        end
        issue(enc_i(OP_SW, 5'd0, 5'd3, 16'h0010));
        issue(enc_r(FN_ADDU, 5'd2, 5'd3, 5'd1, 5'd0));
    endtask

    // few registers, so most operands hit distance one or two
    task automatic run_dependency(input int n);
        issue(enc_i(OP_ORI, 5'd0, 5'd1, imm16_t'($urandom())));
        issue(enc_r(FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
        issue(enc_r(FN_SUBU, 5'd2, 5'd1, 5'd3, 5'd0));
        issue(enc_r(FN_SRA, 5'd0, 5'd3, 5'd1, 5'd7));
        repeat (n) begin
            issue(rand_alu(3));
        end
    endtask

    task automatic run_store_load(input int n);
        reg_idx_t x;
        reg_idx_t y;
        imm16_t   off;
        word_t    v;
        repeat (n) begin
            x   = reg_idx_t'($urandom_range(7, 1));
            y   = reg_idx_t'($urandom_range(7, 1));
            off = imm16_t'({$urandom_range(63, 0), 2'b00});
            v   = $urandom();
            issue(enc_i(OP_LUI, 5'd0, x, v[31:16]));
            issue(enc_i(OP_ORI, x, x, v[15:0]));
            issue(enc_i(OP_SW, 5'd0, x, off));
            issue(enc_i(OP_LW, 5'd0, y, off));
            issue(enc_r(FN_ADDU, y, 5'd0, x, 5'd0));
        end
    endtask

    task automatic run_mixed(input int n);
        int unsigned pick;
        repeat (n) begin
            pick = $urandom_range(19, 0);
            if (pick == 0) begin
                drive_halt($urandom_range(3, 1));
            end else if (pick == 1) begin
                drive_idle();
            end else if (pick < 6) begin
                issue(rand_mem());
            end else begin
                issue(rand_alu(7));
            end
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (pending_writes() > 0 && n < 10) begin
            drive_idle();
            @(negedge clk);
            n++;
        end
        foreach (exp_q[i]) begin
            if (exp_q[i].writes) begin
                $display("write of r%0d from instr %h never reached the writeback port",
                         exp_q[i].dest, exp_q[i].instr);
                missing_errs++;
            end
        end
    endtask

    initial begin
        void'($urandom(19));
        i_rst         = 1'b1;
        i_halt        = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        model_reset();
        repeat (16) @(posedge clk);
        i_rst <= 1'b0;
        check_reset_idle();
        repeat (150) begin
            issue(rand_alu(7));
        end
        run_dependency(120);
        run_store_load(40);
        run_mixed(300);
        drain();
        report_and_finish(1'b0);
    end

endmodule
